// File: Makefile
TOP         ?= l1_data_cache_tb
FILELIST    ?= files.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
VERILATOR   ?= verilator
BUILD_FLAGS ?= --binary --timing --assert
LINT_FLAGS  ?= --lint-only --timing -Wall
PASS_TEXT   ?= >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides pass or fail, the simulator status is not trusted alone
run: build
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qF -- '$(PASS_TEXT)' $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/cache_pkg.sv
package cache_pkg;

  localparam int ADDR_WIDTH = 32;
  localparam int LINE_BYTES = 64;
  localparam int OFFSET_BITS = $clog2(LINE_BYTES);  // Byte offset inside a line

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [3:0]            cmd_code_t;        // Raw trace command number
  typedef logic [31:0]           count_t;

  // Line coherence state, Invalid doubles as the free marker
  typedef enum logic [1:0] {
    modified,
    exclusive,
    shared,
    invalid
  } mesi_t;

  typedef enum logic [2:0] {
    op_read,
    op_write,
    op_invalidate,  // Invalidate from L2
    op_snoop_rfo,   // Snooped read for ownership
    op_clear
  } cache_op_t;

endpackage

// File: design/coherence_controller.sv
module coherence_controller import cache_pkg::*; #(
  parameter  int SET_BITS  = 4,
  parameter  int WAYS      = 8,
  localparam int TAG_BITS  = ADDR_WIDTH - OFFSET_BITS - SET_BITS,
  localparam int RANK_BITS = $clog2(WAYS)
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           op_valid,
  input  cache_op_t                      op,
  input  logic [SET_BITS-1:0]            op_set,
  input  logic [TAG_BITS-1:0]            op_tag,
  input  logic [WAYS-1:0][TAG_BITS-1:0]  way_tags,
  input  mesi_t [WAYS-1:0]               way_states,
  input  logic [WAYS-1:0][RANK_BITS-1:0] way_ranks,
  output logic [SET_BITS-1:0]            rd_set,
  output logic                           wr_en,
  output logic [SET_BITS-1:0]            wr_set,
  output logic [WAYS-1:0][TAG_BITS-1:0]  wr_tags,
  output mesi_t [WAYS-1:0]               wr_states,
  output logic [WAYS-1:0][RANK_BITS-1:0] wr_ranks,
  output logic                           clear_all,
  output logic                           l2_fill,
  output logic                           l2_rfo,
  output logic                           l2_writeback,
  output addr_t                          l2_address,
  output addr_t                          wb_address,
  output count_t                         read_count,
  output count_t                         write_count,
  output count_t                         hit_count,
  output count_t                         miss_count
);

  logic                           hit;
  logic                           free_found;
  logic [RANK_BITS-1:0]           hit_way;
  logic [RANK_BITS-1:0]           free_way;
  logic [RANK_BITS-1:0]           lru_way;
  logic [RANK_BITS-1:0]           victim_way;
  logic [RANK_BITS-1:0]           touch_way;
  logic [RANK_BITS-1:0]           touch_rank;
  logic [WAYS-1:0][RANK_BITS-1:0] lru_ranks;
  addr_t                          line_address;
  addr_t                          evict_address;
  logic                           fill_next;
  logic                           rfo_next;
  logic                           wb_next;
  logic                           read_inc;
  logic                           write_inc;
  logic                           hit_inc;
  logic                           miss_inc;

  assign rd_set = op_set;
  assign wr_set = op_set;  // Read-modify-write of the same set

  assign line_address  = {op_tag, op_set, {OFFSET_BITS{1'b0}}};
  assign evict_address = {way_tags[touch_way], op_set, {OFFSET_BITS{1'b0}}};

  // Scan from the top so the lowest-numbered match is kept
  always_comb
  begin
    hit        = 1'b0;
    hit_way    = '0;
    free_found = 1'b0;
    free_way   = '0;
    lru_way    = '0;
    for (int w = WAYS - 1; w >= 0; w--)
    begin
      if (way_states[w] != invalid && way_tags[w] == op_tag)
      begin
        hit     = 1'b1;
        hit_way = RANK_BITS'(w);
      end
      if (way_states[w] == invalid)
      begin
        free_found = 1'b1;
        free_way   = RANK_BITS'(w);
      end
      if (way_ranks[w] == '0)
        lru_way = RANK_BITS'(w);
    end
  end

  assign victim_way = free_found ? free_way : lru_way;  // Free way beats LRU
  assign touch_way  = hit ? hit_way : victim_way;
  assign touch_rank = way_ranks[touch_way];

  // Touched way becomes most recent, ways above its old rank slide down
  always_comb
  begin
    for (int w = 0; w < WAYS; w++)
    begin
      if (RANK_BITS'(w) == touch_way)
        lru_ranks[w] = RANK_BITS'(WAYS - 1);
      else if (way_ranks[w] > touch_rank)
        lru_ranks[w] = way_ranks[w] - 1'b1;
      else
        lru_ranks[w] = way_ranks[w];
    end
  end

  always_comb
  begin
    wr_en     = 1'b0;
    clear_all = 1'b0;
    wr_tags   = way_tags;
    wr_states = way_states;
    wr_ranks  = way_ranks;
    fill_next = 1'b0;
    rfo_next  = 1'b0;
    wb_next   = 1'b0;
    read_inc  = 1'b0;
    write_inc = 1'b0;
    hit_inc   = 1'b0;
    miss_inc  = 1'b0;
    if (op_valid)
    begin
      case (op)
        op_read, op_write:
        begin
          wr_en     = 1'b1;
          wr_ranks  = lru_ranks;
          read_inc  = (op == op_read);
          write_inc = (op == op_write);
          if (hit)
          begin
            hit_inc = 1'b1;
            if (op == op_write)
              wr_states[hit_way] = modified;
            else if (way_states[hit_way] == exclusive)
              wr_states[hit_way] = shared;  // Exclusive read hit drops to Shared
          end
          else
          begin
            miss_inc              = 1'b1;
            wb_next               = (way_states[victim_way] == modified);
            wr_tags[victim_way]   = op_tag;
            wr_states[victim_way] = (op == op_write) ? modified : exclusive;
            fill_next             = (op == op_read);
            rfo_next              = (op == op_write);
          end
        end
        op_invalidate, op_snoop_rfo:
        begin
          if (hit)  // A miss leaves the set alone
          begin
            wr_en              = 1'b1;
            wr_ranks           = lru_ranks;
            wb_next            = (way_states[hit_way] == modified);
            wr_states[hit_way] = invalid;
          end
        end
        op_clear:
          clear_all = 1'b1;
        default:
          clear_all = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clock, posedge reset)
  begin
    if (reset)
    begin
      l2_fill      <= 1'b0;
      l2_rfo       <= 1'b0;
      l2_writeback <= 1'b0;
      l2_address   <= '0;
      wb_address   <= '0;
      read_count   <= '0;
      write_count  <= '0;
      hit_count    <= '0;
      miss_count   <= '0;
    end
    else
    begin
      l2_fill      <= fill_next;
      l2_rfo       <= rfo_next;
      l2_writeback <= wb_next;
      if (fill_next || rfo_next)
        l2_address <= line_address;
      if (wb_next)
        wb_address <= evict_address;  // Victim line or the snooped line itself
      read_count   <= read_count + count_t'(read_inc);
      write_count  <= write_count + count_t'(write_inc);
      hit_count    <= hit_count + count_t'(hit_inc);
      miss_count   <= miss_count + count_t'(miss_inc);
    end
  end

endmodule

// File: design/l1_data_cache.sv
module l1_data_cache import cache_pkg::*; #(
  parameter  int SET_BITS  = 4,
  parameter  int WAYS      = 8,
  localparam int TAG_BITS  = ADDR_WIDTH - OFFSET_BITS - SET_BITS,
  localparam int RANK_BITS = $clog2(WAYS)
) (
  input  logic      clock,
  input  logic      reset,
  input  logic      cmd_valid,
  input  cmd_code_t cmd_code,
  input  addr_t     cmd_address,
  output logic      l2_fill,
  output logic      l2_rfo,
  output logic      l2_writeback,
  output addr_t     l2_address,
  output addr_t     wb_address,
  output count_t    read_count,
  output count_t    write_count,
  output count_t    hit_count,
  output count_t    miss_count
);

  logic                           op_valid;
  cache_op_t                      op;
  logic [SET_BITS-1:0]            op_set;
  logic [TAG_BITS-1:0]            op_tag;
  logic [SET_BITS-1:0]            rd_set;
  logic [WAYS-1:0][TAG_BITS-1:0]  way_tags;
  mesi_t [WAYS-1:0]               way_states;
  logic [WAYS-1:0][RANK_BITS-1:0] way_ranks;
  logic                           wr_en;
  logic [SET_BITS-1:0]            wr_set;
  logic [WAYS-1:0][TAG_BITS-1:0]  wr_tags;
  mesi_t [WAYS-1:0]               wr_states;
  logic [WAYS-1:0][RANK_BITS-1:0] wr_ranks;
  logic                           clear_all;

  trace_decoder #(
    .SET_BITS (SET_BITS)
  ) trace_decoder_i (
    .clock       (clock),
    .reset       (reset),
    .cmd_valid   (cmd_valid),
    .cmd_code    (cmd_code),
    .cmd_address (cmd_address),
    .op_valid    (op_valid),
    .op          (op),
    .op_set      (op_set),
    .op_tag      (op_tag)
  );

  line_store #(
    .SET_BITS (SET_BITS),
    .WAYS     (WAYS)
  ) line_store_i (
    .clock      (clock),
    .reset      (reset),
    .rd_set     (rd_set),
    .wr_en      (wr_en),
    .wr_set     (wr_set),
    .wr_tags    (wr_tags),
    .wr_states  (wr_states),
    .wr_ranks   (wr_ranks),
    .clear_all  (clear_all),
    .way_tags   (way_tags),
    .way_states (way_states),
    .way_ranks  (way_ranks)
  );

  coherence_controller #(
    .SET_BITS (SET_BITS),
    .WAYS     (WAYS)
  ) coherence_controller_i (
    .clock        (clock),
    .reset        (reset),
    .op_valid     (op_valid),
    .op           (op),
    .op_set       (op_set),
    .op_tag       (op_tag),
    .way_tags     (way_tags),
    .way_states   (way_states),
    .way_ranks    (way_ranks),
    .rd_set       (rd_set),
    .wr_en        (wr_en),
    .wr_set       (wr_set),
    .wr_tags      (wr_tags),
    .wr_states    (wr_states),
    .wr_ranks     (wr_ranks),
    .clear_all    (clear_all),
    .l2_fill      (l2_fill),
    .l2_rfo       (l2_rfo),
    .l2_writeback (l2_writeback),
    .l2_address   (l2_address),
    .wb_address   (wb_address),
    .read_count   (read_count),
    .write_count  (write_count),
    .hit_count    (hit_count),
    .miss_count   (miss_count)
  );

endmodule

// File: design/line_store.sv
module line_store import cache_pkg::*; #(
  parameter  int SET_BITS  = 4,
  parameter  int WAYS      = 8,
  localparam int TAG_BITS  = ADDR_WIDTH - OFFSET_BITS - SET_BITS,
  localparam int RANK_BITS = $clog2(WAYS)
) (
  input  logic                                clock,
  input  logic                                reset,
  input  logic [SET_BITS-1:0]                 rd_set,
  input  logic                                wr_en,
  input  logic [SET_BITS-1:0]                 wr_set,
  input  logic [WAYS-1:0][TAG_BITS-1:0]       wr_tags,
  input  mesi_t [WAYS-1:0]                    wr_states,
  input  logic [WAYS-1:0][RANK_BITS-1:0]      wr_ranks,
  input  logic                                clear_all,
  output logic [WAYS-1:0][TAG_BITS-1:0]       way_tags,
  output mesi_t [WAYS-1:0]                    way_states,
  output logic [WAYS-1:0][RANK_BITS-1:0]      way_ranks
);

  localparam int SETS = 1 << SET_BITS;

  logic [WAYS-1:0][TAG_BITS-1:0]  tag_mem   [SETS];
  mesi_t [WAYS-1:0]               state_mem [SETS];
  logic [WAYS-1:0][RANK_BITS-1:0] rank_mem  [SETS];

  assign way_tags   = tag_mem[rd_set];    // Whole set read, same cycle
  assign way_states = state_mem[rd_set];
  assign way_ranks  = rank_mem[rd_set];

  // Tags only mean something while the state is not Invalid
  always_ff @(posedge clock)
  begin
    if (wr_en)
      tag_mem[wr_set] <= wr_tags;
  end

  always_ff @(posedge clock, posedge reset)
  begin
    if (reset)
    begin
      for (int s = 0; s < SETS; s++)
      begin
        for (int w = 0; w < WAYS; w++)
        begin
          state_mem[s][w] <= invalid;
          rank_mem[s][w]  <= '0;
        end
      end
    end
    else if (clear_all)
    begin
      for (int s = 0; s < SETS; s++)
      begin
        for (int w = 0; w < WAYS; w++)
        begin
          state_mem[s][w] <= invalid;  // Bulk flush of every line
          rank_mem[s][w]  <= '0;
        end
      end
    end
    else if (wr_en)
    begin
      state_mem[wr_set] <= wr_states;
      rank_mem[wr_set]  <= wr_ranks;
    end
  end

endmodule

// File: design/trace_decoder.sv
module trace_decoder import cache_pkg::*; #(
  parameter  int SET_BITS = 4,
  localparam int TAG_BITS = ADDR_WIDTH - OFFSET_BITS - SET_BITS
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                cmd_valid,
  input  cmd_code_t           cmd_code,
  input  addr_t               cmd_address,
  output logic                op_valid,
  output cache_op_t           op,
  output logic [SET_BITS-1:0] op_set,
  output logic [TAG_BITS-1:0] op_tag
);

  cache_op_t decoded_op;
  logic      known_code;

  always_comb
  begin
    known_code = 1'b1;
    decoded_op = op_read;
    case (cmd_code)
      4'd0: decoded_op = op_read;
      4'd1: decoded_op = op_write;
      4'd3: decoded_op = op_invalidate;
      4'd4: decoded_op = op_snoop_rfo;
      4'd8: decoded_op = op_clear;
      default: known_code = 1'b0;  // Fetch, print and spare codes do nothing
    endcase
  end

  always_ff @(posedge clock, posedge reset)
  begin
    if (reset)
      op_valid <= 1'b0;
    else
      op_valid <= cmd_valid && known_code;
  end

  // Byte offset is dropped here, the directory works on whole lines
  always_ff @(posedge clock)
  begin
    if (cmd_valid)
    begin
      op     <= decoded_op;
      op_set <= cmd_address[OFFSET_BITS +: SET_BITS];
      op_tag <= cmd_address[ADDR_WIDTH-1 -: TAG_BITS];
    end
  end

endmodule

// File: files.f
design/cache_pkg.sv
design/trace_decoder.sv
design/line_store.sv
design/coherence_controller.sv
design/l1_data_cache.sv
tb/tb_clock.sv
tb/l1_data_cache_asserts.sv
tb/l1_data_cache_tb.sv

// File: tb/l1_data_cache_asserts.sv
module l1_data_cache_asserts import cache_pkg::*; (
  input logic   clock,
  input logic   reset,
  input logic   l2_fill,
  input logic   l2_rfo,
  input count_t read_count,
  input count_t write_count,
  input count_t hit_count,
  input count_t miss_count
);
  timeunit 1ns;
  timeprecision 1ps;

  // A single access is either a read miss or a write miss
  fill_rfo_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(l2_fill && l2_rfo))
    else $error("l2_fill and l2_rfo pulsed in the same cycle");

  counters_monotonic: assert property (@(posedge clock) disable iff (reset)
    read_count >= $past(read_count) && write_count >= $past(write_count) &&
    hit_count >= $past(hit_count) && miss_count >= $past(miss_count))
    else $error("An event counter decreased outside of reset");

  // Every read or write is counted as exactly one hit or one miss
  hit_miss_balance: assert property (@(posedge clock) disable iff (reset)
    hit_count + miss_count == read_count + write_count)
    else $error("Hits plus misses differ from reads plus writes");

endmodule

bind l1_data_cache l1_data_cache_asserts l1_data_cache_asserts_i (
  .clock       (clock),
  .reset       (reset),
  .l2_fill     (l2_fill),
  .l2_rfo      (l2_rfo),
  .read_count  (read_count),
  .write_count (write_count),
  .hit_count   (hit_count),
  .miss_count  (miss_count)
);

// File: tb/l1_data_cache_tb.sv
module l1_data_cache_tb import cache_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SET_BITS     = 4;
  localparam int WAYS         = 8;
  localparam int SETS         = 1 << SET_BITS;
  localparam int TAG_BITS     = ADDR_WIDTH - OFFSET_BITS - SET_BITS;
  localparam int NUM_COMMANDS = 1900;
  localparam int CYCLE_LIMIT  = NUM_COMMANDS + 100;

  typedef struct packed {
    logic [31:0] index;
    logic        fill;
    logic        rfo;
    logic        writeback;
    addr_t       l2_address;
    addr_t       wb_address;
    count_t      reads;
    count_t      writes;
    count_t      hits;
    count_t      misses;
  } expect_t;

  logic      clock;
  logic      reset;
  logic      cmd_valid;
  cmd_code_t cmd_code;
  addr_t     cmd_address;
  logic      l2_fill;
  logic      l2_rfo;
  logic      l2_writeback;
  addr_t     l2_address;
  addr_t     wb_address;
  count_t    read_count;
  count_t    write_count;
  count_t    hit_count;
  count_t    miss_count;

  logic [31:0]         rng_state;
  int                  cycle_count = 0;
  expect_t             pending[$];  // Expectations waiting out the 2-cycle latency
  logic [TAG_BITS-1:0] model_tags   [SETS][WAYS];
  mesi_t               model_states [SETS][WAYS];
  int                  model_ranks  [SETS][WAYS];
  count_t              exp_reads;
  count_t              exp_writes;
  count_t              exp_hits;
  count_t              exp_misses;
  addr_t               exp_l2_address;  // Address outputs hold between strobes
  addr_t               exp_wb_address;

  tb_clock tb_clock_i (
    .clock (clock),
    .reset (reset)
  );

  l1_data_cache l1_data_cache_i (
    .clock        (clock),
    .reset        (reset),
    .cmd_valid    (cmd_valid),
    .cmd_code     (cmd_code),
    .cmd_address  (cmd_address),
    .l2_fill      (l2_fill),
    .l2_rfo       (l2_rfo),
    .l2_writeback (l2_writeback),
    .l2_address   (l2_address),
    .wb_address   (wb_address),
    .read_count   (read_count),
    .write_count  (write_count),
    .hit_count    (hit_count),
    .miss_count   (miss_count)
  );

  always @(posedge clock)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display(">>> FAIL");
      $fatal(1, "Cycle limit reached");
    end
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Three sets with twelve tags each keep the 8 ways under pressure
  function automatic addr_t pick_address();
    logic [31:0]            set_pick;
    logic [31:0]            tag_pick;
    logic [SET_BITS-1:0]    set_index;
    logic [TAG_BITS-1:0]    tag;
    logic [OFFSET_BITS-1:0] offset;
    set_pick  = (next_random() >> 8) % 32'd3;
    tag_pick  = (next_random() >> 8) % 32'd12;
    offset    = OFFSET_BITS'(next_random() >> 20);
    set_index = SET_BITS'(32'd5 * set_pick + 32'd2);  // Sets 2, 7 and 12
    tag       = TAG_BITS'({14'h1a3b, set_pick[3:0], tag_pick[3:0]});
    return {tag, set_index, offset};
  endfunction

  task automatic reset_model();
    for (int s = 0; s < SETS; s++)
    begin
      for (int w = 0; w < WAYS; w++)
      begin
        model_tags[s][w]   = '0;
        model_states[s][w] = invalid;
        model_ranks[s][w]  = 0;
      end
    end
    exp_reads      = '0;
    exp_writes     = '0;
    exp_hits       = '0;
    exp_misses     = '0;
    exp_l2_address = '0;
    exp_wb_address = '0;
  endtask

  task automatic promote_way(input int set_index, input int way);
    int old_rank;
    old_rank = model_ranks[set_index][way];
    for (int w = 0; w < WAYS; w++)
    begin
      if (w == way)
        model_ranks[set_index][w] = WAYS - 1;
      else if (model_ranks[set_index][w] > old_rank)
        model_ranks[set_index][w] = model_ranks[set_index][w] - 1;
    end
  endtask

  task automatic apply_to_model(input logic valid, input cmd_code_t code, input addr_t address,
                                input logic [31:0] index, output expect_t e);
    int                  set_index;
    logic [TAG_BITS-1:0] tag;
    int                  hit_way;
    int                  victim;
    set_index = int'(address[OFFSET_BITS +: SET_BITS]);
    tag       = address[ADDR_WIDTH-1 -: TAG_BITS];
    hit_way   = -1;
    victim    = -1;
    for (int w = 0; w < WAYS; w++)
    begin
      if (hit_way < 0 && model_states[set_index][w] != invalid && model_tags[set_index][w] == tag)
        hit_way = w;
    end
    e = '0;
    e.index = index;
    if (valid)
    begin
      case (code)
        4'd0, 4'd1:
        begin
          if (code == 4'd0)
            exp_reads++;
          else
            exp_writes++;
          if (hit_way >= 0)
          begin
            exp_hits++;
            if (code == 4'd1)
              model_states[set_index][hit_way] = modified;
            else if (model_states[set_index][hit_way] == exclusive)
              model_states[set_index][hit_way] = shared;  // Read hit on Exclusive gives Shared
            promote_way(set_index, hit_way);
          end
          else
          begin
            exp_misses++;
            for (int w = 0; w < WAYS; w++)
            begin
              if (victim < 0 && model_states[set_index][w] == invalid)
                victim = w;
            end
            for (int w = 0; w < WAYS; w++)
            begin
              if (victim < 0 && model_ranks[set_index][w] == 0)
                victim = w;
            end
            if (victim < 0)
              victim = 0;
            if (model_states[set_index][victim] == modified)
            begin
              e.writeback    = 1'b1;
              exp_wb_address = {model_tags[set_index][victim], SET_BITS'(set_index),
                                {OFFSET_BITS{1'b0}}};
            end
            model_tags[set_index][victim]   = tag;
            model_states[set_index][victim] = (code == 4'd1) ? modified : exclusive;
            promote_way(set_index, victim);
            e.fill         = (code == 4'd0);
            e.rfo          = (code == 4'd1);
            exp_l2_address = {tag, SET_BITS'(set_index), {OFFSET_BITS{1'b0}}};
          end
        end
        4'd3, 4'd4:
        begin
          if (hit_way >= 0)
          begin
            if (model_states[set_index][hit_way] == modified)
            begin
              e.writeback    = 1'b1;
              exp_wb_address = {tag, SET_BITS'(set_index), {OFFSET_BITS{1'b0}}};
            end
            model_states[set_index][hit_way] = invalid;
            promote_way(set_index, hit_way);
          end
        end
        4'd8:
        begin
          for (int s = 0; s < SETS; s++)
          begin
            for (int w = 0; w < WAYS; w++)
            begin
              model_states[s][w] = invalid;
              model_ranks[s][w]  = 0;
            end
          end
        end
        default: ;  // Unused codes leave everything as it was
      endcase
    end
    e.l2_address = exp_l2_address;
    e.wb_address = exp_wb_address;
    e.reads      = exp_reads;
    e.writes     = exp_writes;
    e.hits       = exp_hits;
    e.misses     = exp_misses;
  endtask

  task automatic check_count(input string name, input count_t expected, input count_t actual);
    if (actual !== expected)
    begin
      $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic check_address(input string name, input addr_t expected, input addr_t actual);
    if (actual !== expected)
    begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic check_strobe(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      $display("Fail %s: expected %b, actual %b", name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic compare_outputs(input expect_t e);
    string label;
    label = $sformatf("cmd %0d", e.index);
    check_strobe({label, " l2_fill"}, e.fill, l2_fill);
    check_strobe({label, " l2_rfo"}, e.rfo, l2_rfo);
    check_strobe({label, " l2_writeback"}, e.writeback, l2_writeback);
    check_address({label, " l2_address"}, e.l2_address, l2_address);
    check_address({label, " wb_address"}, e.wb_address, wb_address);
    check_count({label, " read_count"}, e.reads, read_count);
    check_count({label, " write_count"}, e.writes, write_count);
    check_count({label, " hit_count"}, e.hits, hit_count);
    check_count({label, " miss_count"}, e.misses, miss_count);
  endtask

  initial
  begin
    expect_t     expected;
    logic [31:0] pick;
    logic        valid;
    cmd_code_t   code;
    addr_t       address;
    rng_state   = 32'hd2fe7589;
    cmd_valid   = 1'b0;
    cmd_code    = '0;
    cmd_address = '0;
    reset_model();
    @(negedge reset);
    @(posedge clock);
    #1;
    check_strobe("reset l2_fill", 1'b0, l2_fill);
    check_strobe("reset l2_rfo", 1'b0, l2_rfo);
    check_strobe("reset l2_writeback", 1'b0, l2_writeback);
    check_count("reset read_count", '0, read_count);
    check_count("reset write_count", '0, write_count);
    check_count("reset hit_count", '0, hit_count);
    check_count("reset miss_count", '0, miss_count);
    for (int k = 0; k < NUM_COMMANDS + 2; k++)
    begin
      if (pending.size() == 2)
        compare_outputs(pending.pop_front());
      pick    = (next_random() >> 8) % 32'd100;
      address = pick_address();
      valid   = 1'b1;
      if (k >= NUM_COMMANDS || pick < 32'd5)
      begin
        valid = 1'b0;  // Idle cycle, and the final drain
        code  = cmd_code_t'(next_random() >> 28);
      end
      else if (pick < 32'd45)
        code = 4'd0;
      else if (pick < 32'd85)
        code = 4'd1;
      else if (pick < 32'd91)
        code = 4'd3;
      else if (pick < 32'd97)
        code = 4'd4;
      else if (pick < 32'd98)
        code = 4'd8;
      else
      begin
        case ((next_random() >> 8) % 32'd3)
          32'd0: code = 4'd2;
          32'd1: code = 4'd9;
          default: code = 4'd15;
        endcase
      end
      cmd_valid   = valid;
      cmd_code    = code;
      cmd_address = address;
      apply_to_model(valid, code, address, 32'(k), expected);
      pending.push_back(expected);
      @(posedge clock);
      #1;
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

// File: tb/tb_clock.sv
module tb_clock (
  output logic clock,
  output logic reset
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam time HALF_PERIOD = 5ns;  // 10 ns period

  initial
  begin
    clock = 1'b0;
    forever #HALF_PERIOD clock = ~clock;
  end

  initial
  begin
    reset = 1'b1;
    repeat (3) @(posedge clock);
    #1 reset = 1'b0;  // Released just after the third edge
  end

endmodule
